//--- logic/unpack_pkg.sv
/*
 * shared widths and lane count of the operand unpacker
 * element width encoding, per-operand flags and the source word union
 */

package unpack_pkg;

    localparam int unsigned op_cnt  = 3;    // operand lanes
    localparam int unsigned vport_w = 128;  // read port and buffer width
    localparam int unsigned op_w    = 32;   // unpacked operand width
    localparam int unsigned vaddr_w = 5;    // vector register address bits
    localparam int unsigned ctrl_w  = 4;    // control word carried along the pipe

    // element width, 2'b11 is unused
    typedef enum logic [1:0] {
        eew_8  = 2'b00,
        eew_16 = 2'b01,
        eew_32 = 2'b10
    } eew_e;

    // per-operand unpack flags
    typedef struct packed {
        logic load;    // copy the register word into the buffer
        logic vreg;    // source is a vector register, else a scalar
        logic narrow;  // elements are half width and get widened
        logic sigext;  // sign extension when widening
    } op_flags_t;

    // address view of the source word
    typedef struct packed {
        logic [31-vaddr_w:0] pad;
        logic [vaddr_w-1:0]  vaddr;
    } reg_ref_t;

    // one source word with two readings
    // address while issuing, scalar value while extracting
    typedef union packed {
        logic [31:0] xval;
        reg_ref_t    reg_ref;
    } op_src_u;

endpackage

//--- logic/lane_ctrl_if.sv
/*
 * per-lane control bundle from the issue stage to one operand lane
 */

interface lane_ctrl_if import unpack_pkg::*; ();

    // incoming beat, seen in the cycle it is accepted
    logic      beat_take;  // input transfer this cycle
    op_flags_t in_flags;
    op_src_u   in_src;

    // beat held in stage 1
    eew_e      s1_eew;
    op_flags_t s1_flags;
    op_src_u   s1_src;

    modport issue (
        output beat_take,
        output in_flags,
        output in_src,
        output s1_eew,
        output s1_flags,
        output s1_src
    );

    modport lane (
        input  beat_take,
        input  in_flags,
        input  in_src,
        input  s1_eew,
        input  s1_flags,
        input  s1_src
    );

endinterface

//--- logic/unpack_issue.sv
/*
 * first pipeline stage of the unpacker
 * input handshake, stage 1 register and per-lane control fan-out
 */

module unpack_issue import unpack_pkg::*; (
    input  logic                     clk_i,
    input  logic                     async_rst_ni,

    // input beat
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  logic [ctrl_w-1:0]        in_ctrl_i,
    input  eew_e                     in_eew_i,
    input  op_flags_t [op_cnt-1:0]   in_flags_i,
    input  op_src_u   [op_cnt-1:0]   in_src_i,

    // towards the drain stage
    input  logic                     s1_ready_i,   // stage 1 may load this cycle
    output logic                     s1_valid_o,
    output logic [ctrl_w-1:0]        s1_ctrl_o,

    // lane control, one bundle per operand
    lane_ctrl_if.issue               lane_o [op_cnt]
);

    logic                   beat_take;
    logic                   s1_valid_q;
    logic [ctrl_w-1:0]      s1_ctrl_q;
    eew_e                   s1_eew_q;
    op_flags_t [op_cnt-1:0] s1_flags_q;
    op_src_u   [op_cnt-1:0] s1_src_q;

    // stage 1 loads whenever it is ready, so the input sees the same ready
    assign in_ready_o = s1_ready_i;
    assign beat_take  = in_valid_i & s1_ready_i;

    // occupancy of stage 1
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            s1_valid_q <= 1'b0;
        end else if (s1_ready_i) begin
            s1_valid_q <= in_valid_i;   // an empty input leaves a bubble
        end
    end

    // stage 1 payload
    always_ff @(posedge clk_i) begin
        if (s1_ready_i) begin
            s1_ctrl_q  <= in_ctrl_i;
            s1_eew_q   <= in_eew_i;
            s1_flags_q <= in_flags_i;
            s1_src_q   <= in_src_i;
        end
    end

    assign s1_valid_o = s1_valid_q;
    assign s1_ctrl_o  = s1_ctrl_q;

    // every lane gets the shared transfer strobe and eew
    // plus its own flags and source, both for the incoming beat and for stage 1
    for (genvar i = 0; i < op_cnt; i++) begin : gen_fanout
        assign lane_o[i].beat_take = beat_take;
        assign lane_o[i].in_flags  = in_flags_i[i];
        assign lane_o[i].in_src    = in_src_i[i];
        assign lane_o[i].s1_eew    = s1_eew_q;
        assign lane_o[i].s1_flags  = s1_flags_q[i];
        assign lane_o[i].s1_src    = s1_src_q[i];
    end

endmodule

//--- logic/operand_lane.sv
/*
 * one operand lane
 * read addressing, 128-bit operand buffer and operand extraction
 */

module operand_lane import unpack_pkg::*; (
    input  logic               clk_i,
    input  logic               async_rst_ni,

    lane_ctrl_if.lane          ctrl_i,

    // register file read port
    input  logic [vport_w-1:0] rd_data_i,
    output logic [vaddr_w-1:0] rd_addr_o,

    // operand of the beat in stage 1
    output logic [op_w-1:0]    op_data_o
);

    logic [vport_w-1:0] buf_q;
    logic [vport_w-1:0] buf_d;

    // the port is addressed only for an incoming vreg load
    always_comb begin
        rd_addr_o = '0;
        if (ctrl_i.in_flags.load && ctrl_i.in_flags.vreg) begin
            rd_addr_o = ctrl_i.in_src.reg_ref.vaddr;
        end
    end

    // next buffer content for the incoming beat
    always_comb begin
        buf_d = buf_q;   // scalar beats keep the buffer
        if (ctrl_i.in_flags.vreg) begin
            if (ctrl_i.in_flags.load) begin
                buf_d = rd_data_i;
            end else if (ctrl_i.in_flags.narrow) begin
                buf_d = {16'b0, buf_q[vport_w-1:16]};   // half an operand consumed
            end else begin
                buf_d = {{op_w{1'b0}}, buf_q[vport_w-1:op_w]};
            end
        end
    end

    // advances together with stage 1, so the buffer always belongs to the stage 1 beat
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            buf_q <= '0;
        end else if (ctrl_i.beat_take) begin
            buf_q <= buf_d;
        end
    end

    // extraction, scalar first, then narrow, else the low buffer word
    always_comb begin
        op_data_o = buf_q[op_w-1:0];

        if (!ctrl_i.s1_flags.vreg) begin
            // scalar operand, replicate across elements
            unique case (ctrl_i.s1_eew)
                eew_8:   op_data_o = {(op_w/8){ctrl_i.s1_src.xval[7:0]}};
                eew_16:  op_data_o = {(op_w/16){ctrl_i.s1_src.xval[15:0]}};
                eew_32:  op_data_o = ctrl_i.s1_src.xval;
                default: op_data_o = '0;
            endcase
        end else if (ctrl_i.s1_flags.narrow) begin
            op_data_o = '0;   // also the result for narrow at 8 bits
            unique case (ctrl_i.s1_eew)
                eew_16: begin
                    // two bytes, each widened to a halfword
                    for (int j = 0; j < op_w / 16; j++) begin
                        op_data_o[16*j +: 16] = {
                            {8{ctrl_i.s1_flags.sigext & buf_q[8*j + 7]}},
                            buf_q[8*j +: 8]
                        };
                    end
                end
                eew_32: begin
                    // one halfword widened to a word
                    for (int j = 0; j < op_w / 32; j++) begin
                        op_data_o[32*j +: 32] = {
                            {16{ctrl_i.s1_flags.sigext & buf_q[16*j + 15]}},
                            buf_q[16*j +: 16]
                        };
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- logic/unpack_drain.sv
/*
 * output stage of the unpacker
 * stage 2 register, stage ready rule and the valid/ctrl status flags
 */

module unpack_drain import unpack_pkg::*; (
    input  logic                         clk_i,
    input  logic                         async_rst_ni,

    // input beat, only seen for the status flags
    input  logic                         in_valid_i,
    input  logic [ctrl_w-1:0]            in_ctrl_i,

    // stage 1 and the operands extracted from it
    input  logic                         s1_valid_i,
    output logic                         s1_ready_o,
    input  logic [ctrl_w-1:0]            s1_ctrl_i,
    input  logic [op_cnt-1:0][op_w-1:0]  s1_op_data_i,

    // output beat
    output logic                         out_valid_o,
    input  logic                         out_ready_i,
    output logic [ctrl_w-1:0]            out_ctrl_o,
    output logic [op_cnt-1:0][op_w-1:0]  out_op_data_o,

    // status
    output logic                         stage_valid_any_o,
    output logic [ctrl_w-1:0]            ctrl_flags_any_o,
    output logic [ctrl_w-1:0]            ctrl_flags_all_o
);

    logic                        s2_ready;
    logic                        s2_valid_q;
    logic [ctrl_w-1:0]           s2_ctrl_q;
    logic [op_cnt-1:0][op_w-1:0] s2_op_data_q;
    logic [2:0]                  fold_valid;
    logic [2:0][ctrl_w-1:0]      fold_ctrl;

    // empty stages take data even when the output stalls
    assign s2_ready   = out_ready_i | ~s2_valid_q;
    assign s1_ready_o = s2_ready | ~s1_valid_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            s2_valid_q <= 1'b0;
        end else if (s2_ready) begin
            s2_valid_q <= s1_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s2_ready) begin
            s2_ctrl_q    <= s1_ctrl_i;
            s2_op_data_q <= s1_op_data_i;   // operands captured here, one cycle after issue
        end
    end

    assign out_valid_o   = s2_valid_q;
    assign out_ctrl_o    = s2_ctrl_q;
    assign out_op_data_o = s2_op_data_q;

    // input beat, stage 1, stage 2
    assign fold_valid = {s2_valid_q, s1_valid_i, in_valid_i};
    assign fold_ctrl  = {s2_ctrl_q, s1_ctrl_i, in_ctrl_i};

    always_comb begin
        stage_valid_any_o = |fold_valid;
        ctrl_flags_any_o  = '0;
        ctrl_flags_all_o  = '1;
        for (int i = 0; i < 3; i++) begin
            if (fold_valid[i]) begin
                ctrl_flags_any_o = ctrl_flags_any_o | fold_ctrl[i];
                ctrl_flags_all_o = ctrl_flags_all_o & fold_ctrl[i];
            end
        end
    end

endmodule

//--- logic/vreg_unpack.sv
/*
 * top level of the two-stage operand unpacker
 * issue stage, three operand lanes and the drain stage
 */

module vreg_unpack import unpack_pkg::*; (
    input  logic                           clk_i,
    input  logic                           async_rst_ni,

    // input pipe
    input  logic                           pipe_in_valid_i,
    output logic                           pipe_in_ready_o,
    input  logic [ctrl_w-1:0]              pipe_in_ctrl_i,
    input  eew_e                           pipe_in_eew_i,
    input  op_flags_t [op_cnt-1:0]         pipe_in_op_flags_i,
    input  op_src_u   [op_cnt-1:0]         pipe_in_op_src_i,

    // register file read ports, one per lane
    output logic [op_cnt-1:0][vaddr_w-1:0] vreg_rd_addr_o,
    input  logic [op_cnt-1:0][vport_w-1:0] vreg_rd_data_i,

    // output pipe
    output logic                           pipe_out_valid_o,
    input  logic                           pipe_out_ready_i,
    output logic [ctrl_w-1:0]              pipe_out_ctrl_o,
    output logic [op_cnt-1:0][op_w-1:0]    pipe_out_op_data_o,

    // status
    output logic                           stage_valid_any_o,
    output logic [ctrl_w-1:0]              ctrl_flags_any_o,
    output logic [ctrl_w-1:0]              ctrl_flags_all_o
);

    logic                        s1_valid;
    logic                        s1_ready;
    logic [ctrl_w-1:0]           s1_ctrl;
    logic [op_cnt-1:0][op_w-1:0] lane_op_data;

    lane_ctrl_if lane_ctrl [op_cnt] ();

    unpack_issue issue0 (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (pipe_in_valid_i),
        .in_ready_o   (pipe_in_ready_o),
        .in_ctrl_i    (pipe_in_ctrl_i),
        .in_eew_i     (pipe_in_eew_i),
        .in_flags_i   (pipe_in_op_flags_i),
        .in_src_i     (pipe_in_op_src_i),
        .s1_ready_i   (s1_ready),
        .s1_valid_o   (s1_valid),
        .s1_ctrl_o    (s1_ctrl),
        .lane_o       (lane_ctrl)
    );

    for (genvar i = 0; i < op_cnt; i++) begin : gen_lane
        operand_lane lane0 (
            .clk_i        (clk_i),
            .async_rst_ni (async_rst_ni),
            .ctrl_i       (lane_ctrl[i]),
            .rd_data_i    (vreg_rd_data_i[i]),
            .rd_addr_o    (vreg_rd_addr_o[i]),
            .op_data_o    (lane_op_data[i])
        );
    end

    unpack_drain drain0 (
        .clk_i             (clk_i),
        .async_rst_ni      (async_rst_ni),
        .in_valid_i        (pipe_in_valid_i),
        .in_ctrl_i         (pipe_in_ctrl_i),
        .s1_valid_i        (s1_valid),
        .s1_ready_o        (s1_ready),
        .s1_ctrl_i         (s1_ctrl),
        .s1_op_data_i      (lane_op_data),
        .out_valid_o       (pipe_out_valid_o),
        .out_ready_i       (pipe_out_ready_i),
        .out_ctrl_o        (pipe_out_ctrl_o),
        .out_op_data_o     (pipe_out_op_data_o),
        .stage_valid_any_o (stage_valid_any_o),
        .ctrl_flags_any_o  (ctrl_flags_any_o),
        .ctrl_flags_all_o  (ctrl_flags_all_o)
    );

endmodule

//--- tests/unpack_checker.sv
/*
 * watcher for the operand unpacker
 * lane buffer model, expected beat queue, stage occupancy model and status checks
 */

module unpack_checker import unpack_pkg::*; (
    input  logic                           clk_i,
    input  logic                           async_rst_ni,
    input  logic                           in_valid_i,
    input  logic                           in_ready_i,
    input  logic [ctrl_w-1:0]              in_ctrl_i,
    input  eew_e                           in_eew_i,
    input  op_flags_t [op_cnt-1:0]         in_flags_i,
    input  op_src_u   [op_cnt-1:0]         in_src_i,
    input  logic [op_cnt-1:0][vaddr_w-1:0] rd_addr_i,
    input  logic [op_cnt-1:0][vport_w-1:0] rd_data_i,
    input  logic                           out_valid_i,
    input  logic                           out_ready_i,
    input  logic [ctrl_w-1:0]              out_ctrl_i,
    input  logic [op_cnt-1:0][op_w-1:0]    out_data_i,
    input  logic                           valid_any_i,
    input  logic [ctrl_w-1:0]              flags_any_i,
    input  logic [ctrl_w-1:0]              flags_all_i,
    output int                             err_cnt_o,
    output int                             pending_o   // beats accepted but not yet seen at the output
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [ctrl_w-1:0]           ctrl;
        logic [op_cnt-1:0][op_w-1:0] ops;
    } beat_t;

    beat_t              exp_q[$];
    logic [vport_w-1:0] mbuf [op_cnt];   // model of each lane buffer
    logic               m_s1_v;
    logic               m_s2_v;
    logic [ctrl_w-1:0]  m_s1_c;
    logic [ctrl_w-1:0]  m_s2_c;
    int                 err_cnt;
    int                 chk_cnt;
    int                 out_cnt;

    // buffer after an accepted beat
    function automatic logic [vport_w-1:0] next_buffer(op_flags_t f, logic [vport_w-1:0] b,
                                                       logic [vport_w-1:0] rd);
        if (!f.vreg) return b;
        if (f.load) return rd;
        if (f.narrow) return b >> 16;
        return b >> 32;
    endfunction

    // operand of a beat given the buffer it ends up with
    function automatic logic [op_w-1:0] expected_operand(eew_e e, op_flags_t f, op_src_u s,
                                                         logic [vport_w-1:0] b);
        logic sx;
        sx = f.sigext;
        if (!f.vreg) begin
            if (e == eew_8) return {4{s.xval[7:0]}};
            if (e == eew_16) return {2{s.xval[15:0]}};
            if (e == eew_32) return s.xval;
            return '0;
        end
        if (f.narrow) begin
            if (e == eew_16) return {{8{sx & b[15]}}, b[15:8], {8{sx & b[7]}}, b[7:0]};
            if (e == eew_32) return {{16{sx & b[15]}}, b[15:0]};
            return '0;   // narrow at 8 bits
        end
        return b[31:0];
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic print_summary();
        $display("checker: %0d checks, %0d errors, %0d beats out, %0d still expected",
                 chk_cnt, err_cnt, out_cnt, exp_q.size());
    endtask

    // sampled mid-cycle, inputs change 2 ns after the rising edge
    always @(negedge clk_i) begin : watch
        logic              s1_rdy;
        logic              s2_rdy;
        logic [ctrl_w-1:0] e_any;
        logic [ctrl_w-1:0] e_all;
        logic [vaddr_w-1:0] e_addr;
        beat_t             b;
        if (!async_rst_ni) begin
            exp_q.delete();
            for (int i = 0; i < op_cnt; i++) mbuf[i] = '0;
            m_s1_v = 1'b0;
            m_s2_v = 1'b0;
        end else begin
            for (int i = 0; i < op_cnt; i++) begin
                e_addr = (in_flags_i[i].load && in_flags_i[i].vreg) ? in_src_i[i].xval[4:0] : '0;
                check_val($sformatf("lane %0d read address", i), rd_addr_i[i], e_addr);
            end

            // status fold over input beat, stage 1 and stage 2
            e_any = '0;
            e_all = '1;
            if (in_valid_i) begin
                e_any |= in_ctrl_i;
                e_all &= in_ctrl_i;
            end
            if (m_s1_v) begin
                e_any |= m_s1_c;
                e_all &= m_s1_c;
            end
            if (m_s2_v) begin
                e_any |= m_s2_c;
                e_all &= m_s2_c;
            end
            check_val("stage_valid_any", valid_any_i, in_valid_i | m_s1_v | m_s2_v);
            check_val("ctrl_flags_any", flags_any_i, e_any);
            check_val("ctrl_flags_all", flags_all_i, e_all);

            s2_rdy = out_ready_i | ~m_s2_v;
            s1_rdy = s2_rdy | ~m_s1_v;
            check_val("pipe_in_ready", in_ready_i, s1_rdy);
            check_val("pipe_out_valid", out_valid_i, m_s2_v);   // two-cycle latency

            if (out_valid_i && out_ready_i) begin
                out_cnt++;
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("Error at %0t ns: output beat with no accepted beat pending", $time);
                end else begin
                    b = exp_q.pop_front();
                    check_val("output ctrl", out_ctrl_i, b.ctrl);
                    for (int i = 0; i < op_cnt; i++)
                        check_val($sformatf("lane %0d operand", i), out_data_i[i], b.ops[i]);
                end
            end

            if (in_valid_i && in_ready_i) begin
                b.ctrl = in_ctrl_i;
                for (int i = 0; i < op_cnt; i++) begin
                    mbuf[i]   = next_buffer(in_flags_i[i], mbuf[i], rd_data_i[i]);
                    b.ops[i]  = expected_operand(in_eew_i, in_flags_i[i], in_src_i[i], mbuf[i]);
                end
                exp_q.push_back(b);
            end

            // occupancy after the coming edge
            if (s2_rdy) begin
                m_s2_v = m_s1_v;
                m_s2_c = m_s1_c;
            end
            if (s1_rdy) begin
                m_s1_v = in_valid_i;
                m_s1_c = in_ctrl_i;
            end
        end
        err_cnt_o = err_cnt;
        pending_o = exp_q.size();
    end

endmodule

//--- tests/tb_vreg_unpack.sv
/*
 * testbench top for the operand unpacker
 * clock, reset, register file, directed and random beats, output back-pressure
 */

module tb_vreg_unpack import unpack_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic                           clk;
    logic                           rst_n;
    logic                           in_valid;
    logic                           in_ready;
    logic [ctrl_w-1:0]              in_ctrl;
    eew_e                           in_eew;
    op_flags_t [op_cnt-1:0]         in_flags;
    op_src_u   [op_cnt-1:0]         in_src;
    logic [op_cnt-1:0][vaddr_w-1:0] rd_addr;
    logic [op_cnt-1:0][vport_w-1:0] rd_data;
    logic                           out_valid;
    logic                           out_ready;
    logic [ctrl_w-1:0]              out_ctrl;
    logic [op_cnt-1:0][op_w-1:0]    out_data;
    logic                           valid_any;
    logic [ctrl_w-1:0]              flags_any;
    logic [ctrl_w-1:0]              flags_all;
    int                             err_cnt;
    int                             pending;
    integer                         seed;
    logic                           stall_en;   // random output stalls
    logic [vport_w-1:0]             regfile [32];

    always #10 clk = ~clk;

    // register file answers in the same cycle
    for (genvar i = 0; i < op_cnt; i++) begin : gen_rf
        assign rd_data[i] = regfile[rd_addr[i]];
    end

    vreg_unpack dut0 (
        .clk_i (clk), .async_rst_ni (rst_n),
        .pipe_in_valid_i (in_valid), .pipe_in_ready_o (in_ready), .pipe_in_ctrl_i (in_ctrl),
        .pipe_in_eew_i (in_eew), .pipe_in_op_flags_i (in_flags), .pipe_in_op_src_i (in_src),
        .vreg_rd_addr_o (rd_addr), .vreg_rd_data_i (rd_data),
        .pipe_out_valid_o (out_valid), .pipe_out_ready_i (out_ready),
        .pipe_out_ctrl_o (out_ctrl), .pipe_out_op_data_o (out_data),
        .stage_valid_any_o (valid_any), .ctrl_flags_any_o (flags_any),
        .ctrl_flags_all_o (flags_all)
    );

    unpack_checker checker0 (
        .clk_i (clk), .async_rst_ni (rst_n),
        .in_valid_i (in_valid), .in_ready_i (in_ready), .in_ctrl_i (in_ctrl),
        .in_eew_i (in_eew), .in_flags_i (in_flags), .in_src_i (in_src),
        .rd_addr_i (rd_addr), .rd_data_i (rd_data),
        .out_valid_i (out_valid), .out_ready_i (out_ready), .out_ctrl_i (out_ctrl),
        .out_data_i (out_data), .valid_any_i (valid_any), .flags_any_i (flags_any),
        .flags_all_i (flags_all), .err_cnt_o (err_cnt), .pending_o (pending)
    );

    // next cycle, with a fresh output ready (about 30 % stalls when enabled)
    task automatic step();
        @(posedge clk);
        #2;
        out_ready = stall_en ? (($random(seed) & 255) >= 77) : 1'b1;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: no %s within 64 cycles", what);
        checker0.print_summary();
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // present one beat and hold it until accepted
    task automatic send_beat(input logic [ctrl_w-1:0] c, input eew_e e,
                             input op_flags_t [op_cnt-1:0] f, input op_src_u [op_cnt-1:0] s);
        int waited;
        in_valid = 1'b1;
        in_ctrl  = c;
        in_eew   = e;
        in_flags = f;
        in_src   = s;
        waited   = 0;
        @(negedge clk);
        while (!in_ready && waited < 64) begin
            step();
            @(negedge clk);
            waited++;
        end
        if (!in_ready) report_timeout("input handshake");
        else step();
    endtask

    // 0 load, 1-3 shifts, 4 load, 5-7 narrow, 8-11 scalar
    task automatic send_directed(input int k);
        op_flags_t [op_cnt-1:0] f;
        op_src_u   [op_cnt-1:0] s;
        eew_e                   e;
        for (int i = 0; i < op_cnt; i++) begin
            s[i]        = $random(seed);
            f[i].load   = (k == 0) || (k == 4);
            f[i].vreg   = k < 8;
            f[i].narrow = (k > 4) && (k < 8);
            f[i].sigext = i[0];
        end
        e = (k == 5 || k == 6) ? eew_16 : (k >= 8) ? eew_e'(k % 3) : eew_32;
        send_beat(k[ctrl_w-1:0], e, f, s);
    endtask

    task automatic send_random();
        op_flags_t [op_cnt-1:0] f;
        op_src_u   [op_cnt-1:0] s;
        eew_e                   e;
        logic [31:0]            r;
        r = $random(seed);
        e = (r[1:0] == 2'd0) ? eew_8 : (r[1:0] == 2'd1) ? eew_16 : eew_32;
        for (int i = 0; i < op_cnt; i++) begin
            r           = $random(seed);
            f[i].vreg   = r[0] | r[1];
            f[i].load   = f[i].vreg & (r[3:2] == 2'd0);
            f[i].narrow = f[i].vreg & ~f[i].load & r[4] & (e != eew_8);   // no narrow at 8 bits
            f[i].sigext = r[5];
            s[i]        = $random(seed);
        end
        r = $random(seed);
        send_beat(r[ctrl_w-1:0], e, f, s);
    endtask

    initial begin
        int waited;
        seed      = 32'hb6444afb;
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_ctrl   = '0;
        in_eew    = eew_8;
        in_flags  = '0;
        in_src    = '0;
        out_ready = 1'b1;
        stall_en  = 1'b0;
        for (int a = 0; a < 32; a++)
            regfile[a] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        step();
        for (int k = 0; k < 12; k++) send_directed(k);   // output always ready here
        stall_en = 1'b1;
        for (int n = 0; n < 400; n++) begin
            if (($random(seed) & 3) == 0) begin
                in_valid = 1'b0;   // bubble
                step();
            end
            send_random();
        end
        in_valid = 1'b0;
        waited   = 0;
        while (pending != 0 && waited < 64) begin
            step();
            waited++;
        end
        if (pending != 0) report_timeout("drain of the pipeline");
        else begin
            step();
            checker0.print_summary();
            if (err_cnt == 0) $display("TEST RESULT: PASS");
            else $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

//--- compile.f
logic/unpack_pkg.sv
logic/lane_ctrl_if.sv
logic/unpack_issue.sv
logic/operand_lane.sv
logic/unpack_drain.sv
logic/vreg_unpack.sv
tests/unpack_checker.sv
tests/tb_vreg_unpack.sv

//--- Bender.yml
package:
  name: vreg_unpack

sources:
  # package and interface first, then the stages, then the top level
  - logic/unpack_pkg.sv
  - logic/lane_ctrl_if.sv
  - logic/unpack_issue.sv
  - logic/operand_lane.sv
  - logic/unpack_drain.sv
  - logic/vreg_unpack.sv

  - target: test
    files:
      - tests/unpack_checker.sv
      - tests/tb_vreg_unpack.sv
